// File: source/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

   ////////////////////
   // board
   localparam int CLK_FREQ  = 50_000_000; // Hz
   localparam int BAUD_RATE = 115200;

   localparam int CYCLES_PER_BIT_DEFAULT = CLK_FREQ / BAUD_RATE;

   ////////////////////
   // register file
   localparam int DATA_WIDTH = 16;
   localparam int DATA_BYTES = (DATA_WIDTH + 7) / 8; // bytes per word on the wire

   localparam int NUM_ENTRIES_DEFAULT = 8;

   ////////////////////
   // host commands
   localparam logic [7:0] CMD_READ  = 8'h00;
   localparam logic [7:0] CMD_WRITE = 8'h01;

endpackage

`default_nettype wire

// File: source/sync_2ff.sv
`timescale 1ns/100ps
`default_nettype none

module sync_2ff #(
   parameter int              WIDTH    = 1,
   parameter logic [WIDTH-1:0] INIT_VAL = '0
) (
   input  wire              clk,
   input  wire              n_rst,
   input  wire  [WIDTH-1:0] i_d,
   output logic [WIDTH-1:0] o_q
);

   logic [WIDTH-1:0] meta; // first stage, may go metastable

   always_ff @(posedge clk) begin
      if (!n_rst) begin
         meta <= INIT_VAL;
         o_q  <= INIT_VAL;
      end else begin
         meta <= i_d;
         o_q  <= meta;
      end
   end

endmodule

`default_nettype wire

// File: source/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
   parameter int CYCLES_PER_BIT = dbg_pkg::CYCLES_PER_BIT_DEFAULT
) (
   input  wire        clk,
   input  wire        n_rst,
   input  wire        i_rxd,
   output logic [7:0] o_data,
   output logic       o_valid
);

   localparam int CNT_W = $clog2(CYCLES_PER_BIT);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CYCLES_PER_BIT - 1);
   localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CYCLES_PER_BIT / 2 - 1);

   localparam logic [1:0] S_IDLE  = 2'd0;
   localparam logic [1:0] S_START = 2'd1;
   localparam logic [1:0] S_DATA  = 2'd2;
   localparam logic [1:0] S_STOP  = 2'd3;

   logic [1:0]       state;
   logic [CNT_W-1:0] cnt;
   logic [2:0]       bit_idx;
   logic             sample; // middle of a data bit

   assign sample = (state == S_DATA) && (cnt == CNT_LAST);

   ////////////////////
   // bit timing
   always_ff @(posedge clk) begin
      if (!n_rst) begin
         state   <= S_IDLE;
         cnt     <= '0;
         bit_idx <= '0;
         o_valid <= 1'b0;
      end else begin
         o_valid <= 1'b0;
         cnt     <= cnt + 1'b1;
         case (state)
            S_IDLE: begin
               cnt     <= '0;
               bit_idx <= '0;
               if (!i_rxd)
                  state <= S_START;
            end
            S_START: begin
               // realign the counter to mid-bit
               if (cnt == CNT_HALF) begin
                  cnt   <= '0;
                  state <= i_rxd ? S_IDLE : S_DATA; // glitch, not a start bit
               end
            end
            S_DATA: begin
               if (cnt == CNT_LAST) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= S_STOP;
               end
            end
            default: begin
               if (cnt == CNT_LAST) begin
                  state   <= S_IDLE;
                  o_valid <= i_rxd; // low stop bit drops the byte
               end
            end
         endcase
      end
   end

   // lsb first
   always_ff @(posedge clk) begin
      if (sample)
         o_data <= {i_rxd, o_data[7:1]};
   end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx #(
   parameter int CYCLES_PER_BIT = dbg_pkg::CYCLES_PER_BIT_DEFAULT
) (
   input  wire       clk,
   input  wire       n_rst,
   input  wire [7:0] i_data,
   input  wire       i_start,
   output logic      o_txd,
   output logic      o_done
);

   localparam int CNT_W = $clog2(CYCLES_PER_BIT);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CYCLES_PER_BIT - 1);

   logic             busy;
   logic [CNT_W-1:0] cnt;
   logic [3:0]       bit_idx;
   logic [9:0]       shreg; // stop, data, start

   assign o_txd = shreg[0]; // all ones while idle

   always_ff @(posedge clk) begin
      if (!n_rst) begin
         busy    <= 1'b0;
         cnt     <= '0;
         bit_idx <= '0;
         shreg   <= '1;
         o_done  <= 1'b0;
      end else begin
         o_done <= 1'b0;
         if (!busy) begin
            cnt     <= '0;
            bit_idx <= '0;
            if (i_start) begin
               shreg <= {1'b1, i_data, 1'b0};
               busy  <= 1'b1;
            end
         end else if (cnt == CNT_LAST) begin
            cnt     <= '0;
            shreg   <= {1'b1, shreg[9:1]};
            bit_idx <= bit_idx + 1'b1;
            // end of the stop bit
            if (bit_idx == 4'd9) begin
               busy   <= 1'b0;
               o_done <= 1'b1;
            end
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/cmd_endpoint.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_endpoint #(
   parameter int NUM_ENTRIES = dbg_pkg::NUM_ENTRIES_DEFAULT
) (
   input  wire                               clk,
   input  wire                               n_rst,
   // receiver
   input  wire  [7:0]                        i_rx_data,
   input  wire                               i_rx_valid,
   // transmitter
   output logic [7:0]                        o_tx_data,
   output logic                              o_tx_start,
   input  wire                               i_tx_done,
   // register file write
   output logic                              o_wr_en,
   output logic [$clog2(NUM_ENTRIES)-1:0]    o_wr_addr,
   output logic [dbg_pkg::DATA_WIDTH-1:0]    o_wr_data,
   // register file read
   output logic                              o_rd_req,
   output logic [$clog2(NUM_ENTRIES)-1:0]    o_rd_addr,
   input  wire                               i_rd_ack,
   input  wire  [dbg_pkg::DATA_WIDTH-1:0]    i_rd_data
);

   import dbg_pkg::*;

   localparam int ADDR_W = $clog2(NUM_ENTRIES);
   localparam int CNT_W  = (DATA_BYTES > 1) ? $clog2(DATA_BYTES) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DATA_BYTES - 1);

   localparam logic [2:0] ST_IDLE  = 3'd0;
   localparam logic [2:0] ST_ADDR  = 3'd1;
   localparam logic [2:0] ST_WDATA = 3'd2;
   localparam logic [2:0] ST_RWAIT = 3'd3;
   localparam logic [2:0] ST_RSEND = 3'd4;

   logic [2:0]            state;
   logic [CNT_W-1:0]      byte_cnt;
   logic [7:0]            cmd;
   logic [ADDR_W-1:0]     addr;
   logic [DATA_WIDTH-1:0] word_buf; // incoming bytes, low byte first
   logic [DATA_WIDTH-1:0] tx_buf;   // reply, shifted out low byte first

   assign o_wr_addr = addr;
   assign o_rd_addr = addr;
   assign o_wr_data = word_buf;
   assign o_tx_data = tx_buf[7:0];

   ////////////////////
   // command FSM
   always_ff @(posedge clk) begin
      if (!n_rst) begin
         state      <= ST_IDLE;
         byte_cnt   <= '0;
         o_wr_en    <= 1'b0;
         o_rd_req   <= 1'b0;
         o_tx_start <= 1'b0;
      end else begin
         o_wr_en    <= 1'b0;
         o_tx_start <= 1'b0;
         case (state)
            ST_IDLE: begin
               byte_cnt <= '0;
               if (i_rx_valid)
                  state <= ST_ADDR;
            end
            ST_ADDR: begin
               if (i_rx_valid) begin
                  if (cmd == CMD_WRITE) begin
                     state <= ST_WDATA;
                  end else if (cmd == CMD_READ) begin
                     o_rd_req <= 1'b1;
                     state    <= ST_RWAIT;
                  end else begin
                     state <= ST_IDLE; // unknown command, address swallowed
                  end
               end
            end
            ST_WDATA: begin
               if (i_rx_valid) begin
                  byte_cnt <= byte_cnt + 1'b1;
                  if (byte_cnt == CNT_LAST) begin
                     o_wr_en <= 1'b1;
                     state   <= ST_IDLE;
                  end
               end
            end
            ST_RWAIT: begin
               if (i_rd_ack) begin
                  o_rd_req   <= 1'b0;
                  o_tx_start <= 1'b1;
                  state      <= ST_RSEND;
               end
            end
            ST_RSEND: begin
               // next byte only after the previous stop bit
               if (i_tx_done) begin
                  if (byte_cnt == CNT_LAST) begin
                     state <= ST_IDLE;
                  end else begin
                     byte_cnt   <= byte_cnt + 1'b1;
                     o_tx_start <= 1'b1;
                  end
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   ////////////////////
   // byte assembly
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && i_rx_valid)
         cmd <= i_rx_data;
      if (state == ST_ADDR && i_rx_valid)
         addr <= i_rx_data[ADDR_W-1:0]; // high address bits ignored
      if (state == ST_WDATA && i_rx_valid)
         word_buf <= {i_rx_data, word_buf[DATA_WIDTH-1:8]};
      if (state == ST_RWAIT && i_rd_ack)
         tx_buf <= i_rd_data;
      else if (state == ST_RSEND && i_tx_done)
         tx_buf <= {8'h00, tx_buf[DATA_WIDTH-1:8]};
   end

endmodule

`default_nettype wire

// File: source/dbg_reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_reg_file #(
   parameter int NUM_ENTRIES = dbg_pkg::NUM_ENTRIES_DEFAULT
) (
   input  wire                            clk,
   input  wire                            n_rst,
   input  wire                            i_wr_en,
   input  wire  [$clog2(NUM_ENTRIES)-1:0] i_wr_addr,
   input  wire  [dbg_pkg::DATA_WIDTH-1:0] i_wr_data,
   input  wire                            i_rd_req,
   input  wire  [$clog2(NUM_ENTRIES)-1:0] i_rd_addr,
   output logic                           o_rd_ack,
   output logic [dbg_pkg::DATA_WIDTH-1:0] o_rd_data,
   input  wire  [dbg_pkg::DATA_WIDTH-1:0] i_board_in,
   output logic [dbg_pkg::DATA_WIDTH-1:0] o_display
);

   import dbg_pkg::*;

   localparam int ADDR_W = $clog2(NUM_ENTRIES);
   localparam int NUM_WR = NUM_ENTRIES / 2;

   logic [DATA_WIDTH-1:0] regs [NUM_WR];
   logic [DATA_WIDTH-1:0] board_q;  // input snapshot
   logic [DATA_WIDTH-1:0] rd_mux;
   logic                  rd_req_q;

   assign o_display = regs[0];

   always_ff @(posedge clk) begin
      if (!n_rst) begin
         for (int i = 0; i < NUM_WR; i++)
            regs[i] <= '0;
      end else if (i_wr_en) begin
         for (int i = 0; i < NUM_WR; i++)
            if (i_wr_addr == ADDR_W'(i))
               regs[i] <= i_wr_data; // upper half is read only
      end
   end

   always_ff @(posedge clk) begin
      board_q <= i_board_in;
   end

   // lower half writable, then inputs, rest zero
   always_comb begin
      rd_mux = '0;
      for (int i = 0; i < NUM_WR; i++)
         if (i_rd_addr == ADDR_W'(i))
            rd_mux = regs[i];
      if (i_rd_addr == ADDR_W'(NUM_WR))
         rd_mux = board_q;
   end

   ////////////////////
   // read handshake, ack two cycles after req
   always_ff @(posedge clk) begin
      if (!n_rst) begin
         rd_req_q <= 1'b0;
         o_rd_ack <= 1'b0;
      end else begin
         rd_req_q <= i_rd_req;
         o_rd_ack <= i_rd_req && rd_req_q && !o_rd_ack; // single pulse
      end
   end

   always_ff @(posedge clk) begin
      if (rd_req_q)
         o_rd_data <= rd_mux;
   end

endmodule

`default_nettype wire

// File: source/hex_display.sv
`timescale 1ns/100ps
`default_nettype none

module hex_display (
   input  wire  [dbg_pkg::DATA_WIDTH-1:0] i_value,
   output logic [6:0]                     o_seg0,
   output logic [6:0]                     o_seg1,
   output logic [6:0]                     o_seg2,
   output logic [6:0]                     o_seg3
);

   // active low, segment a in bit 0
   function automatic logic [6:0] seg_font(input logic [3:0] nib);
      case (nib)
         4'h0: seg_font = 7'b1000000;
         4'h1: seg_font = 7'b1111001;
         4'h2: seg_font = 7'b0100100;
         4'h3: seg_font = 7'b0110000;
         4'h4: seg_font = 7'b0011001;
         4'h5: seg_font = 7'b0010010;
         4'h6: seg_font = 7'b0000010;
         4'h7: seg_font = 7'b1111000;
         4'h8: seg_font = 7'b0000000;
         4'h9: seg_font = 7'b0010000;
         4'ha: seg_font = 7'b0001000;
         4'hb: seg_font = 7'b0000011;
         4'hc: seg_font = 7'b1000110;
         4'hd: seg_font = 7'b0100001;
         4'he: seg_font = 7'b0000110;
         default: seg_font = 7'b0001110;
      endcase
   endfunction

   assign o_seg0 = seg_font(i_value[3:0]); // lowest nibble
   assign o_seg1 = seg_font(i_value[7:4]);
   assign o_seg2 = seg_font(i_value[11:8]);
   assign o_seg3 = seg_font(i_value[15:12]);

endmodule

`default_nettype wire

// File: source/dbg_board_top.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_board_top #(
   parameter int CYCLES_PER_BIT = dbg_pkg::CYCLES_PER_BIT_DEFAULT,
   parameter int NUM_ENTRIES    = dbg_pkg::NUM_ENTRIES_DEFAULT
) (
   input  wire        clk,
   input  wire        n_rst,
   input  wire        i_uart_rx,
   output logic       o_uart_tx,
   input  wire  [3:0] i_key,
   input  wire  [7:0] i_sw,
   output logic [6:0] o_hex0,
   output logic [6:0] o_hex1,
   output logic [6:0] o_hex2,
   output logic [6:0] o_hex3
);

   import dbg_pkg::*;

   localparam int ADDR_W = $clog2(NUM_ENTRIES);

   logic                  rx_sync;
   logic [11:0]           keys_sw_sync;
   logic [DATA_WIDTH-1:0] board_in;
   logic [7:0]            rx_data;
   logic                  rx_valid;
   logic [7:0]            tx_data;
   logic                  tx_start;
   logic                  tx_done;
   logic                  wr_en;
   logic [ADDR_W-1:0]     wr_addr;
   logic [DATA_WIDTH-1:0] wr_data;
   logic                  rd_req;
   logic [ADDR_W-1:0]     rd_addr;
   logic                  rd_ack;
   logic [DATA_WIDTH-1:0] rd_data;
   logic [DATA_WIDTH-1:0] display;

   ////////////////////
   // input synchronizers, rx idles high
   sync_2ff #(.WIDTH(1), .INIT_VAL(1'b1)) u_sync_rx (
      .clk(clk), .n_rst(n_rst), .i_d(i_uart_rx), .o_q(rx_sync)
   );

   sync_2ff #(.WIDTH(12), .INIT_VAL(12'h000)) u_sync_in (
      .clk(clk), .n_rst(n_rst), .i_d({i_key, i_sw}), .o_q(keys_sw_sync)
   );

   assign board_in = {4'h0, keys_sw_sync};

   ////////////////////
   // serial link
   uart_rx #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) u_rx (
      .clk(clk), .n_rst(n_rst), .i_rxd(rx_sync), .o_data(rx_data), .o_valid(rx_valid)
   );

   uart_tx #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) u_tx (
      .clk(clk), .n_rst(n_rst), .i_data(tx_data), .i_start(tx_start),
      .o_txd(o_uart_tx), .o_done(tx_done)
   );

   cmd_endpoint #(.NUM_ENTRIES(NUM_ENTRIES)) u_ep (
      .clk(clk), .n_rst(n_rst),
      .i_rx_data(rx_data), .i_rx_valid(rx_valid),
      .o_tx_data(tx_data), .o_tx_start(tx_start), .i_tx_done(tx_done),
      .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data),
      .o_rd_req(rd_req), .o_rd_addr(rd_addr), .i_rd_ack(rd_ack), .i_rd_data(rd_data)
   );

   dbg_reg_file #(.NUM_ENTRIES(NUM_ENTRIES)) u_regs (
      .clk(clk), .n_rst(n_rst),
      .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
      .i_rd_req(rd_req), .i_rd_addr(rd_addr), .o_rd_ack(rd_ack), .o_rd_data(rd_data),
      .i_board_in(board_in), .o_display(display)
   );

   hex_display u_hex (
      .i_value(display),
      .o_seg0(o_hex0), .o_seg1(o_hex1), .o_seg2(o_hex2), .o_seg3(o_hex3)
   );

endmodule

`default_nettype wire

// File: tests/tb_dbg_board.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dbg_board;

   localparam int BIT_CYCLES  = 16;
   localparam int NUM_CMDS    = 40;
   localparam int WATCHDOG_NS = NUM_CMDS * 30 * 10 * BIT_CYCLES * 20;
   localparam int REPLY_LIMIT = 40 * BIT_CYCLES; // in cycles

   localparam logic [7:0] CMD_RD = 8'h00;
   localparam logic [7:0] CMD_WR = 8'h01;

   logic        clk;
   logic        n_rst;
   logic        rxd;
   logic        txd;
   logic [3:0]  key;
   logic [7:0]  sw;
   logic [6:0]  hex0;
   logic [6:0]  hex1;
   logic [6:0]  hex2;
   logic [6:0]  hex3;
   logic [15:0] lfsr;
   logic [15:0] model [4]; // writable entries
   logic [6:0]  font [16];
   int          errors;
   int          checks;

   dbg_board_top #(.CYCLES_PER_BIT(BIT_CYCLES)) dut (
      .clk(clk), .n_rst(n_rst), .i_uart_rx(rxd), .o_uart_tx(txd),
      .i_key(key), .i_sw(sw),
      .o_hex0(hex0), .o_hex1(hex1), .o_hex2(hex2), .o_hex3(hex3)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("ERROR: watchdog expired before the tests finished");
      $display("TEST RESULT: FAIL");
      $finish;
   end

   ////////////////////
   // random numbers

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[14:0], lfsr[0]};
      end
   endtask

   ////////////////////
   // model and checks
   function automatic logic [15:0] expected_read(input logic [2:0] a);
      if (a < 3'd4)
         return model[a[1:0]];
      if (a == 3'd4)
         return {4'h0, key, sw};
      return 16'h0000;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic verify_display();
      @(negedge clk);
      check_value("o_hex0", 32'(hex0), 32'(font[model[0][3:0]]));
      check_value("o_hex1", 32'(hex1), 32'(font[model[0][7:4]]));
      check_value("o_hex2", 32'(hex2), 32'(font[model[0][11:8]]));
      check_value("o_hex3", 32'(hex3), 32'(font[model[0][15:12]]));
   endtask

   ////////////////////
   // host side of the serial link
   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         rxd <= frame[i];
         repeat (BIT_CYCLES - 1) @(posedge clk);
      end
      @(posedge clk); // end of stop bit
   endtask

   task automatic recv_byte(output logic [7:0] b);
      int waited;
      waited = 0;
      b      = '0;
      @(negedge clk);
      while (txd === 1'b1 && waited < REPLY_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (txd !== 1'b0) begin
         errors++;
         $display("ERROR: no reply byte arrived within 40 bit times, at %0t ns", $time);
      end else begin
         repeat (BIT_CYCLES / 2) @(negedge clk); // mid start bit
         for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            b[i] = txd;
         end
         repeat (BIT_CYCLES) @(negedge clk);
         check_value("o_uart_tx stop bit", 32'(txd), 32'd1);
      end
   endtask

   task automatic write_word(input logic [7:0] addr, input logic [15:0] w);
      send_byte(CMD_WR);
      send_byte(addr);
      send_byte(w[7:0]);
      send_byte(w[15:8]);
      if (addr[2:0] < 3'd4)
         model[addr[1:0]] = w;
   endtask

   task automatic read_word(input logic [7:0] addr, output logic [15:0] w);
      logic [7:0] lo;
      logic [7:0] hi;
      send_byte(CMD_RD);
      // reply may start before the address stop bit ends
      fork
         send_byte(addr);
         recv_byte(lo);
      join
      recv_byte(hi);
      repeat (BIT_CYCLES / 2) @(posedge clk);
      w = {hi, lo};
   endtask

   task automatic read_and_compare(input logic [7:0] addr);
      logic [15:0] got;
      read_word(addr, got);
      check_value($sformatf("read data of entry %0d", addr[2:0]), 32'(got),
                  32'(expected_read(addr[2:0])));
   endtask

   task automatic wait_for_silence(input int cycles);
      bit seen;
      seen = 1'b0;
      for (int i = 0; i < cycles; i++) begin
         @(negedge clk);
         if (txd !== 1'b1)
            seen = 1'b1;
      end
      if (seen) begin
         errors++;
         $display("ERROR: unknown command produced a reply, at %0t ns", $time);
      end
   endtask

   initial begin
      logic [15:0] w;
      logic [15:0] a;
      logic [15:0] r;
      errors = 0;
      checks = 0;
      lfsr   = 16'd47744;
      font   = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
      for (int i = 0; i < 4; i++)
         model[i] = 16'h0000;
      n_rst <= 1'b0;
      rxd   <= 1'b1;
      key   <= 4'h0;
      sw    <= 8'h00;
      repeat (2) @(posedge clk);
      n_rst <= 1'b1;
      repeat (4) @(posedge clk);

      // idle line and all digits zero
      @(negedge clk);
      check_value("o_uart_tx", 32'(txd), 32'd1);
      verify_display();

      for (int i = 0; i < 4; i++) begin
         rand_bits(16, w);
         write_word(8'h00, w);
         repeat (4) @(posedge clk);
         verify_display();
      end

      // writable half
      for (int i = 0; i < 8; i++) begin
         rand_bits(2, a);
         rand_bits(16, w);
         write_word({6'd0, a[1:0]}, w);
      end
      verify_display();
      for (int i = 0; i < 4; i++)
         read_and_compare(8'(i));

      // board inputs and the zero entries
      for (int i = 0; i < 2; i++) begin
         rand_bits(12, a);
         @(posedge clk);
         key <= a[11:8];
         sw  <= a[7:0];
         repeat (10) @(posedge clk);
         read_and_compare(8'd4);
      end
      for (int i = 5; i < 8; i++)
         read_and_compare(8'(i));
      rand_bits(16, w);
      write_word(8'd5, w);
      read_and_compare(8'd5);

      // high address bits are don't care
      for (int i = 0; i < 4; i++) begin
         rand_bits(8, a);
         rand_bits(16, w);
         write_word(a[7:0], w);
         rand_bits(5, r);
         read_and_compare({r[4:0], a[2:0]});
      end

      ////////////////////
      // unknown commands
      for (int i = 0; i < 3; i++) begin
         a = 16'h0000;
         while (a[7:0] == CMD_RD || a[7:0] == CMD_WR)
            rand_bits(8, a);
         rand_bits(8, r);
         send_byte(a[7:0]);
         fork
            send_byte(r[7:0]);
            wait_for_silence(REPLY_LIMIT);
         join
         verify_display();
         rand_bits(2, r);
         read_and_compare({6'd0, r[1:0]});
      end

      $display("tests done: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
source/dbg_pkg.sv
source/sync_2ff.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_endpoint.sv
source/dbg_reg_file.sv
source/hex_display.sv
source/dbg_board_top.sv
tests/tb_dbg_board.sv

// File: Makefile
TOP := tb_dbg_board
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "TEST RESULT: PASS" $(LOG) || \
		(echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
